//--- hdl/rv_core_pkg.sv
package rv_core_pkg;

  // widths
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [xlen-1:0]       inst_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [2:0]            funct3_t;

  localparam word_t reset_vector = 32'h8000_0000;

  // major opcodes
  localparam logic [6:0] op_reg    = 7'b011_0011;
  localparam logic [6:0] op_imm    = 7'b001_0011;
  localparam logic [6:0] op_lui    = 7'b011_0111;
  localparam logic [6:0] op_auipc  = 7'b001_0111;
  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_jalr   = 7'b110_0111;
  localparam logic [6:0] op_branch = 7'b110_0011;
  localparam logic [6:0] op_system = 7'b111_0011;

  // alu funct3, shared by register and immediate forms
  localparam funct3_t f3_add  = 3'b000; // add, sub, addi
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101; // srl or sra by alt
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // branch conditions
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // funct7 with bit 30 set, marks sub and sra
  localparam logic [6:0] funct7_alt = 7'b010_0000;

  typedef enum logic {src_reg, src_imm} alu_src_e;

  typedef enum logic [1:0] {
    wb_alu,       // alu result
    wb_link,      // pc + 4
    wb_imm_u,     // lui
    wb_pc_target  // auipc
  } wb_sel_e;

  typedef enum logic [1:0] {pc_seq, pc_branch, pc_jal, pc_jalr} pc_sel_e;

endpackage

//--- hdl/rv_decoder.sv
`timescale 1ns/100ps

module rv_decoder (
  input  rv_core_pkg::inst_t     inst,
  output rv_core_pkg::reg_addr_t rs1,
  output rv_core_pkg::reg_addr_t rs2,
  output rv_core_pkg::reg_addr_t rd,
  output rv_core_pkg::funct3_t   funct3,
  output rv_core_pkg::word_t     imm,
  output rv_core_pkg::word_t     imm_u,
  output logic                   alt,
  output rv_core_pkg::alu_src_e  alu_src,
  output rv_core_pkg::wb_sel_e   wb_sel,
  output rv_core_pkg::pc_sel_e   pc_sel,
  output logic                   reg_wen,
  output logic                   is_ebreak
);
  import rv_core_pkg::*;

  logic [6:0] opcode;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_j;
  logic       is_shift_imm;

  assign opcode = inst[6:0];
  assign funct7 = inst[31:25];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  // sign extended immediates
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};

  // slli, srli, srai take only shamt
  assign is_shift_imm = (funct3 == f3_sll) || (funct3 == f3_sr);

  // only the exact encoding 0x00100073
  assign is_ebreak = (inst == {12'h001, 13'h0000, op_system});

  always_comb begin
    imm     = '0;
    alt     = 1'b0;
    alu_src = src_reg;
    wb_sel  = wb_alu;
    pc_sel  = pc_seq;
    reg_wen = 1'b0;
    case (opcode)
      op_reg: begin
        alt     = (funct7 == funct7_alt); // sub, sra
        reg_wen = 1'b1;
      end
      op_imm: begin
        imm     = is_shift_imm ? {27'h0, inst[24:20]} : imm_i;
        alt     = (funct3 == f3_sr) && (funct7 == funct7_alt); // srai only
        alu_src = src_imm;
        reg_wen = 1'b1;
      end
      op_lui: begin
        imm     = imm_u;
        wb_sel  = wb_imm_u;
        reg_wen = 1'b1;
      end
      op_auipc: begin
        imm     = imm_u; // pc unit adds it to pc
        wb_sel  = wb_pc_target;
        reg_wen = 1'b1;
      end
      op_jal: begin
        imm     = imm_j;
        wb_sel  = wb_link;
        pc_sel  = pc_jal;
        reg_wen = 1'b1;
      end
      op_jalr: begin
        imm     = imm_i;
        wb_sel  = wb_link;
        pc_sel  = pc_jalr;
        reg_wen = 1'b1;
      end
      op_branch: begin
        imm    = imm_b;
        pc_sel = pc_branch; // compare sees rs1 vs rs2
      end
      default: begin
        // system and unknown opcodes, nothing written
      end
    endcase
  end

endmodule

//--- hdl/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   wen,
  input  rv_core_pkg::reg_addr_t waddr,
  input  rv_core_pkg::reg_addr_t raddr1,
  input  rv_core_pkg::reg_addr_t raddr2,
  input  rv_core_pkg::word_t     wdata,
  output rv_core_pkg::word_t     rdata1,
  output rv_core_pkg::word_t     rdata2
);
  import rv_core_pkg::*;

  word_t regs [1:31]; // no storage behind x0

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- hdl/rv_compare.sv
`timescale 1ns/100ps

module rv_compare (
  input  rv_core_pkg::word_t a,
  input  rv_core_pkg::word_t b,
  output logic               eq,
  output logic               lt,
  output logic               ltu
);
  import rv_core_pkg::*;

  logic [xlen:0] diff; // extra bit catches the borrow
  logic          overflow;

  assign diff = {1'b0, a} - {1'b0, b};

  // signs differ and result sign flipped away from a
  assign overflow = (a[xlen-1] != b[xlen-1]) && (diff[xlen-1] != a[xlen-1]);

  assign eq  = (diff[xlen-1:0] == '0);
  assign lt  = diff[xlen-1] ^ overflow;
  assign ltu = diff[xlen]; // borrow out means a < b unsigned

endmodule

//--- hdl/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
  input  rv_core_pkg::word_t     rs1_data,
  input  rv_core_pkg::word_t     rs2_data,
  input  rv_core_pkg::word_t     imm,
  input  rv_core_pkg::alu_src_e  alu_src,
  input  rv_core_pkg::funct3_t   funct3,
  input  logic                   alt,
  input  logic                   lt,
  input  logic                   ltu,
  output rv_core_pkg::word_t     operand_a,
  output rv_core_pkg::word_t     operand_b,
  output rv_core_pkg::word_t     result
);
  import rv_core_pkg::*;

  word_t      add_sub;
  logic [4:0] shamt;

  assign operand_a = rs1_data;
  assign operand_b = (alu_src == src_imm) ? imm : rs2_data;

  assign add_sub = alt ? (operand_a - operand_b) : (operand_a + operand_b);
  assign shamt   = operand_b[4:0]; // upper bits ignored

  always_comb begin
    case (funct3)
      f3_add: begin
        result = add_sub;
      end
      f3_sll: begin
        result = operand_a << shamt;
      end
      f3_slt: begin
        result = {31'h0, lt}; // flags from the compare unit
      end
      f3_sltu: begin
        result = {31'h0, ltu};
      end
      f3_xor: begin
        result = operand_a ^ operand_b;
      end
      f3_sr: begin
        if (alt) begin
          result = $signed(operand_a) >>> shamt;
        end else begin
          result = operand_a >> shamt;
        end
      end
      f3_or: begin
        result = operand_a | operand_b;
      end
      default: begin // f3_and
        result = operand_a & operand_b;
      end
    endcase
  end

endmodule

//--- hdl/rv_pc_unit.sv
`timescale 1ns/100ps

module rv_pc_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_core_pkg::pc_sel_e  pc_sel,
  input  rv_core_pkg::funct3_t  funct3,
  input  logic                  eq,
  input  logic                  lt,
  input  logic                  ltu,
  input  rv_core_pkg::word_t    imm,
  input  rv_core_pkg::word_t    rs1_data,
  input  logic                  is_ebreak,
  output rv_core_pkg::word_t    pc,
  output rv_core_pkg::word_t    pc_plus4,
  output rv_core_pkg::word_t    pc_target,
  output logic                  halt
);
  import rv_core_pkg::*;

  logic  taken;
  word_t jalr_target;
  word_t next_pc;

  always_comb begin
    case (funct3)
      f3_beq:  taken = eq;
      f3_bne:  taken = !eq;
      f3_blt:  taken = lt;
      f3_bge:  taken = !lt;
      f3_bltu: taken = ltu;
      f3_bgeu: taken = !ltu;
      default: taken = 1'b0; // reserved encodings fall through
    endcase
  end

  assign pc_plus4    = pc + 32'd4;
  assign pc_target   = pc + imm; // branch, jal, auipc
  assign jalr_target = (rs1_data + imm) & ~32'h1;

  always_comb begin
    case (pc_sel)
      pc_branch: next_pc = taken ? pc_target : pc_plus4;
      pc_jal:    next_pc = pc_target;
      pc_jalr:   next_pc = jalr_target;
      default:   next_pc = pc_plus4;
    endcase
  end

  // pc stays on the ebreak once halted
  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= reset_vector;
      halt <= 1'b0;
    end else if (!halt) begin
      if (is_ebreak) begin
        halt <= 1'b1;
      end else begin
        pc <= next_pc;
      end
    end
  end

endmodule

//--- hdl/rv_core_top.sv
`timescale 1ns/100ps

module rv_core_top (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_core_pkg::inst_t     inst,
  output rv_core_pkg::word_t     pc,
  output logic                   halt,
  output logic                   wb_en,
  output rv_core_pkg::reg_addr_t wb_addr,
  output rv_core_pkg::word_t     wb_data
);
  import rv_core_pkg::*;

  reg_addr_t rs1, rs2, rd;
  funct3_t   funct3;
  word_t     imm, imm_u;
  logic      alt, reg_wen, is_ebreak;
  alu_src_e  alu_src;
  wb_sel_e   wb_sel;
  pc_sel_e   pc_sel;
  word_t     rs1_data, rs2_data;
  word_t     operand_a, operand_b, alu_result;
  logic      eq, lt, ltu;
  word_t     pc_plus4, pc_target;

  rv_decoder u_decoder (
    .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .funct3(funct3), .imm(imm),
    .imm_u(imm_u), .alt(alt), .alu_src(alu_src), .wb_sel(wb_sel), .pc_sel(pc_sel),
    .reg_wen(reg_wen), .is_ebreak(is_ebreak)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst(rst), .wen(wb_en), .waddr(rd), .raddr1(rs1), .raddr2(rs2),
    .wdata(wb_data), .rdata1(rs1_data), .rdata2(rs2_data)
  );

  rv_alu u_alu (
    .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .alu_src(alu_src),
    .funct3(funct3), .alt(alt), .lt(lt), .ltu(ltu), .operand_a(operand_a),
    .operand_b(operand_b), .result(alu_result)
  );

  rv_compare u_compare (.a(operand_a), .b(operand_b), .eq(eq), .lt(lt), .ltu(ltu));

  rv_pc_unit u_pc_unit (
    .clk(clk), .rst(rst), .pc_sel(pc_sel), .funct3(funct3), .eq(eq), .lt(lt),
    .ltu(ltu), .imm(imm), .rs1_data(rs1_data), .is_ebreak(is_ebreak), .pc(pc),
    .pc_plus4(pc_plus4), .pc_target(pc_target), .halt(halt)
  );

  assign wb_en   = reg_wen && !halt; // no writes once halted
  assign wb_addr = rd;

  always_comb begin
    unique case (wb_sel)
      wb_alu:       wb_data = alu_result;
      wb_link:      wb_data = pc_plus4;  // jal, jalr
      wb_imm_u:     wb_data = imm_u;
      wb_pc_target: wb_data = pc_target; // auipc
    endcase
  end

endmodule

//--- verif/rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb;
  import rv_core_pkg::*;

  localparam int reset_cycles = 5;
  localparam int rounds       = 4;
  // reset, alu rounds, lui/auipc, branches, jumps, ebreak
  localparam int total_insts  = 4 + rounds * 23 + 4 + 24 + 3 + 6;
  localparam inst_t nop_inst    = 32'h0000_0013;
  localparam inst_t ebreak_inst = 32'h0010_0073;

  logic      clk;
  logic      rst;
  inst_t     inst;
  word_t     pc, wb_data;
  logic      halt, wb_en;
  reg_addr_t wb_addr;

  word_t model_regs [32]; // architectural state as the ISA defines it
  word_t exp_pc;
  logic  exp_halt;
  word_t rng_state   = 32'h0df617a8;
  int    errors      = 0;
  int    errors_seen = 0;
  int    checks      = 0;
  int    tests       = 0;

  rv_core_top dut0 (.clk(clk), .rst(rst), .inst(inst), .pc(pc), .halt(halt),
                    .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data));

  always #4 clk = ~clk;

  initial begin // twice the expected run time
    #((total_insts + reset_cycles) * 8 * 2);
    $display("watchdog expired before the tests finished");
    $display("sim failed");
    $finish;
  end

  function automatic word_t xorshift();
    word_t x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic inst_t enc_r(input logic [6:0] f7, input funct3_t f3, input reg_addr_t rd,
                                  input reg_addr_t rs1, input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic inst_t enc_i(input logic [6:0] op, input funct3_t f3, input reg_addr_t rd,
                                  input reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic inst_t enc_b(input funct3_t f3, input reg_addr_t rs1, input reg_addr_t rs2,
                                  input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic inst_t enc_u(input logic [6:0] op, input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic inst_t enc_j(input reg_addr_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  // integer result by the ISA rules
  function automatic word_t alu(input funct3_t f, input logic alt, input word_t a, input word_t b);
    case (f)
      f3_add:  return alt ? a - b : a + b;
      f3_sll:  return a << b[4:0];
      f3_slt:  return {31'h0, $signed(a) < $signed(b)};
      f3_sltu: return {31'h0, a < b};
      f3_xor:  return a ^ b;
      f3_sr: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      f3_or:   return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s = %08h, expected %08h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s = %02h, expected %02h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s = %0h, expected %0h", name, got, exp);
    end
  endtask

  // one instruction per cycle, outputs checked at the falling edge
  task automatic exec(input inst_t i);
    word_t a, b, imm_i, data, npc;
    logic  en, taken;
    inst  <= i;
    a     = model_regs[i[19:15]];
    b     = model_regs[i[24:20]];
    imm_i = {{20{i[31]}}, i[31:20]};
    en    = !exp_halt && (i[6:0] inside {op_reg, op_imm, op_lui, op_auipc, op_jal, op_jalr});
    data  = exp_pc + 4; // link value for jal and jalr
    npc   = exp_pc + 4;
    case (i[6:0])
      op_reg:   data = alu(i[14:12], i[30], a, b);
      op_imm:   data = alu(i[14:12], i[30] && (i[14:12] == f3_sr), a, imm_i);
      op_lui:   data = {i[31:12], 12'h000};
      op_auipc: data = exp_pc + {i[31:12], 12'h000};
      op_jal:   npc = exp_pc + {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
      op_jalr:  npc = (a + imm_i) & 32'hffff_fffe;
      op_branch: begin
        case (i[14:12])
          f3_beq:  taken = (a == b);
          f3_bne:  taken = (a != b);
          f3_blt:  taken = ($signed(a) < $signed(b));
          f3_bge:  taken = ($signed(a) >= $signed(b));
          f3_bltu: taken = (a < b);
          f3_bgeu: taken = (a >= b);
          default: taken = 1'b0;
        endcase
        if (taken) npc = exp_pc + {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
      end
      default: if (i == ebreak_inst) npc = exp_pc;
    endcase
    if (exp_halt) npc = exp_pc; // halted core holds its pc
    @(negedge clk);
    check_word("pc", pc, exp_pc);
    check_bit("halt", halt, exp_halt);
    check_bit("wb_en", wb_en, en);
    if (en) begin
      check_addr("wb_addr", wb_addr, i[11:7]);
      check_word("wb_data", wb_data, data);
    end
    @(posedge clk);
    if (en && i[11:7] != 5'd0) model_regs[i[11:7]] = data;
    exp_halt = exp_halt || (i == ebreak_inst);
    exp_pc   = npc;
  endtask

  task automatic load_reg(input reg_addr_t rd, input word_t v);
    word_t hi;
    hi = v + 32'h800; // addi sign-extends the low part
    exec(enc_u(op_lui, rd, hi[31:12]));
    exec(enc_i(op_imm, f3_add, rd, rd, v[11:0]));
  endtask

  task automatic report_test(input string name);
    tests++;
    if (errors == errors_seen) $display("test %s done, no errors", name);
    else $display("test %s done, %0d errors", name, errors - errors_seen);
    errors_seen = errors;
  endtask

  task automatic test_reset();
    rst <= 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0; // first instruction goes in on this same edge
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    exp_pc   = 32'h8000_0000;
    exp_halt = 1'b0;
    exec(enc_i(op_imm, f3_add, 5'd0, 5'd0, 12'h5a5)); // x0 stays zero
    load_reg(5'd1, 32'hcafe_1234);
    exec(enc_r(7'h00, f3_add, 5'd2, 5'd0, 5'd1));
    report_test("reset");
  endtask

  task automatic test_alu();
    word_t r;
    for (int n = 0; n < rounds; n++) begin
      load_reg(5'd1, xorshift());
      load_reg(5'd2, xorshift());
      for (int f = 0; f < 8; f++) begin
        exec(enc_r(7'h00, funct3_t'(f), reg_addr_t'(3 + f), 5'd1, 5'd2));
      end
      exec(enc_r(funct7_alt, f3_add, 5'd11, 5'd1, 5'd2)); // sub
      exec(enc_r(funct7_alt, f3_sr, 5'd12, 5'd1, 5'd2));  // sra
      for (int f = 0; f < 8; f++) begin
        r = xorshift();
        if (f == 1 || f == 5) r[11:5] = 7'h00; // slli, srli
        exec(enc_i(op_imm, funct3_t'(f), reg_addr_t'(13 + f), 5'd1, r[11:0]));
      end
      r = xorshift();
      exec(enc_i(op_imm, f3_sr, 5'd21, 5'd1, {funct7_alt, r[4:0]})); // srai
    end
    report_test("alu");
  endtask

  task automatic test_upper();
    word_t r;
    for (int n = 0; n < 2; n++) begin
      r = xorshift();
      exec(enc_u(op_lui, 5'd5, r[31:12]));
      exec(enc_u(op_auipc, 5'd6, r[19:0]));
    end
    report_test("upper");
  endtask

  task automatic test_branch();
    load_reg(5'd1, 32'h8000_0000); // negative signed, large unsigned
    load_reg(5'd2, 32'h0000_0001);
    load_reg(5'd3, 32'h0000_0001);
    for (int f = 0; f < 8; f++) begin
      if (f == 2 || f == 3) continue;
      exec(enc_b(funct3_t'(f), 5'd1, 5'd2, 13'd16));
      exec(enc_b(funct3_t'(f), 5'd2, 5'd1, 13'h1ff8)); // back 8
      exec(enc_b(funct3_t'(f), 5'd2, 5'd3, 13'd12));
    end
    report_test("branch");
  endtask

  task automatic test_jump();
    exec(enc_j(5'd1, 21'd20));
    exec(enc_i(op_jalr, 3'b000, 5'd5, 5'd1, 12'h00d)); // odd sum, bit 0 dropped
    exec(enc_j(5'd7, 21'h1ffff4));                     // back 12
    report_test("jump");
  endtask

  task automatic test_halt();
    exec(enc_i(op_imm, f3_add, 5'd4, 5'd0, 12'h005));
    exec(ebreak_inst);
    repeat (4) exec(enc_i(op_imm, f3_add, 5'd4, 5'd0, 12'h009));
    report_test("halt");
  endtask

  initial begin
    clk   = 1'b0;
    rst  <= 1'b1;
    inst <= nop_inst;
    test_reset();
    test_alu();
    test_upper();
    test_branch();
    test_jump();
    test_halt();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- files.f
hdl/rv_core_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_compare.sv
hdl/rv_alu.sv
hdl/rv_pc_unit.sv
hdl/rv_core_top.sv
verif/rv_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

build_dir=build
log="$build_dir/sim.log"
mkdir -p "$build_dir" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f files.f --top-module rv_core_tb \
  -Mdir "$build_dir/obj" -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"$build_dir/obj/rv_core_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$log"; then
  exit 1
fi
exit 0
